// ==== files.f ====
+incdir+hdl
hdl/dma_pkg.sv
hdl/chan_load_if.sv
hdl/desc_fetch.sv
hdl/chan_engine.sv
hdl/dma_top.sv
verif/dma_properties.sv
verif/wb_mem_model.sv
verif/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the DMA testbench with Verilator, run it and search the log for the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module dma_tb -f files.f -o dma_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dma_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
   exit 0
fi
exit 1

// ==== verif/dma_tb.sv ====
// directed testbench for the two-channel descriptor DMA sequencer
// lays out descriptor tables in the memory model, kicks the fetch controller
// and checks the channel strobe addresses, dar_o, busy_o and the interrupt

`include "dma_cfg.svh"

module dma_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // 12 descriptors at under 25 cycles each plus 38 words and idle waits
   // stay below 500 cycles, 4000 leaves a wide margin
   localparam int TIMEOUT_CYCLES = 4000;

   logic           wb_clk_i = 1'b0;
   logic           wb_rst_i;
   logic           enable_i;
   logic [31:3]    ndar_i;
   logic           ndar_dirty_i;
   logic           int_clear_i;
   dma_pkg::word_t wbm_dat_hi_i;
   logic           wbm_ack_i;
   logic           wbm_cyc_o;
   logic           wbm_stb_o;
   logic [3:0]     wbm_sel_o;
   dma_pkg::word_t wbm_adr_o;
   logic           ndar_dirty_clear_o;
   logic           wb_int_o;
   logic           busy_o;
   dma_pkg::word_t dar_o;
   logic           chan_a_stb_o;
   dma_pkg::word_t chan_a_adr_o;
   logic           chan_b_stb_o;
   dma_pkg::word_t chan_b_adr_o;

   dma_pkg::word_t q_a[$];     // strobe addresses seen on each channel
   dma_pkg::word_t q_b[$];
   dma_pkg::word_t exp_a[$];   // expected addresses for the current test
   dma_pkg::word_t exp_b[$];
   int cycle_cnt = 0;
   int last_stb_cyc = 0;
   int clear_pulses = 0;
   int cyc_cycles = 0;
   int bad_sel = 0;            // strobe cycles without all byte lanes
   int base_a;
   int base_b;
   int base_clear;
   int base_cyc;
   int base_sel;
   int err_base;
   int busy_fall_cyc;
   int tests = 0;
   int checks = 0;
   int errors = 0;

   always #4 wb_clk_i = ~wb_clk_i;

   dma_top u_dut (.*);

   wb_mem_model u_mem (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .wbs_cyc_i    (wbm_cyc_o),
      .wbs_stb_i    (wbm_stb_o),
      .wbs_adr_i    (wbm_adr_o),
      .wbs_ack_o    (wbm_ack_i),
      .wbs_dat_hi_o (wbm_dat_hi_i)
   );

   always @(posedge wb_clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // channel and bus monitors, sampled mid-cycle
   always @(negedge wb_clk_i) begin
      if (!wb_rst_i) begin
         if (chan_a_stb_o) begin
            q_a.push_back(chan_a_adr_o);
            last_stb_cyc = cycle_cnt;
         end
         if (chan_b_stb_o) begin
            q_b.push_back(chan_b_adr_o);
            last_stb_cyc = cycle_cnt;
         end
         if (ndar_dirty_clear_o) clear_pulses++;
         if (wbm_cyc_o) cyc_cycles++;
         if (wbm_stb_o && wbm_sel_o !== 4'hf) bad_sel++;
      end
   end

   task automatic word_eq(input string name, input dma_pkg::word_t got,
                          input dma_pkg::word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic count_eq(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic bit_eq(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   function automatic dma_pkg::dc_t make_dc(input int len, input logic chain,
                                            input logic irq);
      dma_pkg::dc_t dc;
      dc       = '0;
      dc.len   = len[`DMA_LEN_W-1:0];
      dc.chain = chain;
      dc.irq   = irq;
      return dc;
   endfunction

   // one descriptor, high words of beats 0 to 3
   task automatic put_desc(input dma_pkg::word_t adr, input dma_pkg::word_t next,
                           input dma_pkg::dc_t dc, input dma_pkg::word_t start);
      int idx;
      idx = int'(adr[10:3]);
      u_mem.mem_hi[idx]     = next;
      u_mem.mem_hi[idx + 1] = {8'h00, dc};
      u_mem.mem_hi[idx + 2] = start;
      u_mem.mem_hi[idx + 3] = 32'h0;
   endtask

   task automatic add_strobes(input logic on_b, input dma_pkg::word_t start, input int len);
      for (int i = 0; i < len; i++) begin
         if (on_b) exp_b.push_back(start + 32'(i * `DMA_ADR_STEP));
         else exp_a.push_back(start + 32'(i * `DMA_ADR_STEP));
      end
   endtask

   task automatic compare_strobes();
      count_eq("chan_a_stb_o count", q_a.size() - base_a, exp_a.size());
      foreach (exp_a[i]) begin
         if (base_a + i < q_a.size()) word_eq("chan_a_adr_o", q_a[base_a + i], exp_a[i]);
      end
      count_eq("chan_b_stb_o count", q_b.size() - base_b, exp_b.size());
      foreach (exp_b[i]) begin
         if (base_b + i < q_b.size()) word_eq("chan_b_adr_o", q_b[base_b + i], exp_b[i]);
      end
      count_eq("wbm_sel_o cycles not 4'hf", bad_sel - base_sel, 0);
   endtask

   task automatic open_test();
      base_a     = q_a.size();
      base_b     = q_b.size();
      base_clear = clear_pulses;
      base_cyc   = cyc_cycles;
      base_sel   = bad_sel;
      err_base   = errors;
      exp_a.delete();
      exp_b.delete();
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("test %-16s %s", name, (errors == err_base) ? "ok" : "FAILED");
   endtask

   // point at a chain, wait for the dirty clear, then for busy_o to fall
   task automatic start_and_wait(input dma_pkg::word_t adr);
      @(posedge wb_clk_i);
      #1;
      ndar_i       = adr[31:3];
      ndar_dirty_i = 1'b1;
      enable_i     = 1'b1;
      @(negedge wb_clk_i);
      while (!ndar_dirty_clear_o) @(negedge wb_clk_i);
      @(posedge wb_clk_i);
      #1;
      ndar_dirty_i = 1'b0;
      @(negedge wb_clk_i);
      while (busy_o) @(negedge wb_clk_i);
      busy_fall_cyc = cycle_cnt;
   endtask

   task automatic single_desc();
      open_test();
      put_desc(32'h100, 32'h0, make_dc(5, 1'b0, 1'b0), 32'h1000_0000);
      add_strobes(1'b0, 32'h1000_0000, 5);
      start_and_wait(32'h100);
      compare_strobes();
      word_eq("dar_o", dar_o, 32'h100);
      count_eq("ndar_dirty_clear_o pulses", clear_pulses - base_clear, 1);
      report_test("single");
   endtask

   task automatic chained_pair();
      open_test();
      put_desc(32'h200, 32'h240, make_dc(3, 1'b1, 1'b0), 32'h2000_0000);
      put_desc(32'h240, 32'h0, make_dc(9, 1'b0, 1'b0), 32'h3000_0100);
      add_strobes(1'b0, 32'h2000_0000, 3);
      add_strobes(1'b1, 32'h3000_0100, 9);
      start_and_wait(32'h200);
      compare_strobes();
      bit_eq("busy_o past last strobe", busy_fall_cyc > last_stb_cyc, 1'b1);
      word_eq("dar_o", dar_o, 32'h240);
      report_test("pair");
   endtask

   task automatic four_desc_chain();
      open_test();
      put_desc(32'h300, 32'h340, make_dc(2, 1'b1, 1'b0), 32'h4000_0000);
      put_desc(32'h340, 32'h380, make_dc(4, 1'b1, 1'b0), 32'h5000_0000);
      put_desc(32'h380, 32'h3c0, make_dc(6, 1'b1, 1'b0), 32'h6000_0040);
      put_desc(32'h3c0, 32'h0, make_dc(1, 1'b0, 1'b0), 32'h7000_0000);
      add_strobes(1'b0, 32'h4000_0000, 2);
      add_strobes(1'b1, 32'h5000_0000, 4);
      add_strobes(1'b0, 32'h6000_0040, 6);
      add_strobes(1'b1, 32'h7000_0000, 1);
      start_and_wait(32'h300);
      compare_strobes();
      word_eq("dar_o", dar_o, 32'h3c0);
      count_eq("ndar_dirty_clear_o pulses", clear_pulses - base_clear, 1);
      report_test("four_chain");
   endtask

   task automatic irq_and_clear();
      open_test();
      put_desc(32'h400, 32'h440, make_dc(2, 1'b1, 1'b0), 32'h0800_0000);
      put_desc(32'h440, 32'h0, make_dc(3, 1'b0, 1'b1), 32'h0900_0000);
      add_strobes(1'b0, 32'h0800_0000, 2);
      add_strobes(1'b1, 32'h0900_0000, 3);
      start_and_wait(32'h400);
      bit_eq("wb_int_o", wb_int_o, 1'b1);
      repeat (3) @(negedge wb_clk_i);
      bit_eq("wb_int_o", wb_int_o, 1'b1);   // held until cleared
      @(posedge wb_clk_i);
      #1;
      int_clear_i = 1'b1;
      @(posedge wb_clk_i);
      #1;
      int_clear_i = 1'b0;
      @(negedge wb_clk_i);
      bit_eq("wb_int_o", wb_int_o, 1'b0);
      put_desc(32'h480, 32'h4c0, make_dc(1, 1'b1, 1'b0), 32'h0a00_0000);
      put_desc(32'h4c0, 32'h0, make_dc(2, 1'b0, 1'b0), 32'h0b00_0000);
      add_strobes(1'b0, 32'h0a00_0000, 1);
      add_strobes(1'b1, 32'h0b00_0000, 2);
      start_and_wait(32'h480);
      bit_eq("wb_int_o", wb_int_o, 1'b0);
      compare_strobes();
      report_test("irq");
   endtask

   task automatic idle_and_zero();
      open_test();
      @(posedge wb_clk_i);
      #1;
      enable_i     = 1'b0;
      ndar_i       = 29'h0a0;   // descriptor at 0x500
      ndar_dirty_i = 1'b1;
      repeat (20) @(negedge wb_clk_i);
      count_eq("wbm_cyc_o cycles", cyc_cycles - base_cyc, 0);
      count_eq("ndar_dirty_clear_o pulses", clear_pulses - base_clear, 0);
      bit_eq("busy_o", busy_o, 1'b0);
      compare_strobes();
      put_desc(32'h500, 32'h0, make_dc(0, 1'b0, 1'b0), 32'h0c00_0000);
      start_and_wait(32'h500);
      compare_strobes();
      repeat (4) @(negedge wb_clk_i);   // no restart once the pointer is clean
      bit_eq("busy_o", busy_o, 1'b0);
      word_eq("dar_o", dar_o, 32'h500);
      report_test("idle_zero");
   endtask

   initial begin
      wb_rst_i     = 1'b1;
      enable_i     = 1'b0;
      ndar_i       = '0;
      ndar_dirty_i = 1'b0;
      int_clear_i  = 1'b0;
      repeat (8) @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;
      single_desc();
      chained_pair();
      four_desc_chain();
      irq_and_clear();
      idle_and_zero();
      errors += u_dut.u_fetch.u_props.fail_cnt;   // assertion failures
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== verif/wb_mem_model.sv ====
// Wishbone read memory for the DMA testbench, holds the descriptor tables
// each beat is acked after 0 to 3 wait cycles picked by an xorshift generator
// the testbench writes mem_hi directly to lay out descriptors

module wb_mem_model (
   input  logic           wb_clk_i,
   input  logic           wb_rst_i,
   input  logic           wbs_cyc_i,
   input  logic           wbs_stb_i,
   input  dma_pkg::word_t wbs_adr_i,
   output logic           wbs_ack_o,
   output dma_pkg::word_t wbs_dat_hi_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH = 256;   // 8-byte beats, 2 KB

   dma_pkg::word_t mem_hi [DEPTH];   // high word of each 64-bit beat
   logic           ack_q = 1'b0;
   dma_pkg::word_t dat_q = '0;
   logic [31:0]    rnd = 32'h4312e57a;
   int             wait_left = 0;    // wait cycles before the next ack

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem_hi[i] = 32'hbad0_0000 | (32'(i) << 3);   // byte address as fill
      end
   end

   // ack for the coming edge is decided just after the clock
   always @(posedge wb_clk_i) begin
      #1;
      if (wb_rst_i || !(wbs_cyc_i && wbs_stb_i)) begin
         ack_q = 1'b0;
      end else if (wait_left == 0) begin
         ack_q     = 1'b1;
         dat_q     = mem_hi[wbs_adr_i[10:3]];
         rnd       = xorshift32(rnd);
         wait_left = int'(rnd[1:0]);   // delay of the next beat
      end else begin
         ack_q     = 1'b0;
         wait_left = wait_left - 1;
      end
   end

   assign wbs_ack_o    = ack_q;
   assign wbs_dat_hi_o = dat_q;

endmodule

// ==== verif/dma_properties.sv ====
// concurrent checks on the fetch controller's Wishbone master and channel starts
// bound into every desc_fetch instance by the bind at the end of this file

module dma_properties (
   input logic                  wb_clk_i,
   input logic                  wb_rst_i,
   input dma_pkg::fetch_state_e state_i,
   input logic                  cyc_i,
   input logic                  stb_i,
   input logic                  ack_i,
   input dma_pkg::word_t        adr_i,
   input logic                  busy_i,
   input logic                  start_a_i,
   input logic                  start_b_i,
   input logic                  done_a_i,
   input logic                  done_b_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;   // assertion failures so far

   stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_i |-> (cyc_i &&
                 (state_i == dma_pkg::S_FETCH_A || state_i == dma_pkg::S_FETCH_B)))
      else begin
         fail_cnt++;
         $error("wishbone stb high without cyc or outside a fetch");
      end

   adr_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (stb_i && !ack_i) |=> $stable(adr_i))
      else begin
         fail_cnt++;
         $error("wishbone address moved while waiting for ack");
      end

   start_a_quiet: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      start_a_i |-> done_a_i)
      else begin
         fail_cnt++;
         $error("channel A started while still strobing");
      end

   start_b_quiet: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      start_b_i |-> done_b_i)
      else begin
         fail_cnt++;
         $error("channel B started while still strobing");
      end

   idle_not_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (state_i == dma_pkg::S_IDLE) |-> !busy_i)
      else begin
         fail_cnt++;
         $error("busy high in the idle state");
      end

endmodule

bind desc_fetch dma_properties u_props (
   .wb_clk_i  (wb_clk_i),
   .wb_rst_i  (wb_rst_i),
   .state_i   (state),
   .cyc_i     (wbm_cyc_o),
   .stb_i     (wbm_stb_o),
   .ack_i     (wbm_ack_i),
   .adr_i     (wbm_adr_o),
   .busy_i    (busy_o),
   .start_a_i (start_a),
   .start_b_i (start_b),
   .done_a_i  (ld_a.done),
   .done_b_i  (ld_b.done)
);

// ==== hdl/dma_top.sv ====
// top level of the two-channel descriptor DMA sequencer
// one fetch controller on the Wishbone read port feeds two channel engines
// through a load interface each; all external signals are plain ports

module dma_top (
   input  logic           wb_clk_i,
   input  logic           wb_rst_i,
   input  logic           enable_i,
   input  logic [31:3]    ndar_i,
   input  logic           ndar_dirty_i,
   input  logic           int_clear_i,
   input  dma_pkg::word_t wbm_dat_hi_i,
   input  logic           wbm_ack_i,
   output logic           wbm_cyc_o,
   output logic           wbm_stb_o,
   output logic [3:0]     wbm_sel_o,
   output dma_pkg::word_t wbm_adr_o,
   output logic           ndar_dirty_clear_o,
   output logic           wb_int_o,
   output logic           busy_o,
   output dma_pkg::word_t dar_o,
   output logic           chan_a_stb_o,
   output dma_pkg::word_t chan_a_adr_o,
   output logic           chan_b_stb_o,
   output dma_pkg::word_t chan_b_adr_o
);

   chan_load_if ld_a_if (.wb_clk_i(wb_clk_i));   // first descriptor of a pair
   chan_load_if ld_b_if (.wb_clk_i(wb_clk_i));   // linked descriptor

   desc_fetch u_fetch (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .enable_i           (enable_i),
      .ndar_i             (ndar_i),
      .ndar_dirty_i       (ndar_dirty_i),
      .int_clear_i        (int_clear_i),
      .wbm_dat_hi_i       (wbm_dat_hi_i),
      .wbm_ack_i          (wbm_ack_i),
      .wbm_cyc_o          (wbm_cyc_o),
      .wbm_stb_o          (wbm_stb_o),
      .wbm_sel_o          (wbm_sel_o),
      .wbm_adr_o          (wbm_adr_o),
      .ndar_dirty_clear_o (ndar_dirty_clear_o),
      .wb_int_o           (wb_int_o),
      .busy_o             (busy_o),
      .dar_o              (dar_o),
      .ld_a               (ld_a_if.fetch),
      .ld_b               (ld_b_if.fetch)
   );

   chan_engine u_chan_a (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .ld       (ld_a_if.chan),
      .stb_o    (chan_a_stb_o),
      .adr_o    (chan_a_adr_o)
   );

   chan_engine u_chan_b (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .ld       (ld_b_if.chan),
      .stb_o    (chan_b_stb_o),
      .adr_o    (chan_b_adr_o)
   );

endmodule

// ==== hdl/chan_engine.sv ====
// one DMA channel: captures its descriptor from the load strobes and, on start,
// issues one address strobe per word, stepping by the configured byte step
// done is high whenever the channel is not strobing

`include "dma_cfg.svh"

module chan_engine (
   input  logic           wb_clk_i,
   input  logic           wb_rst_i,
   chan_load_if.chan      ld,
   output logic           stb_o,
   output dma_pkg::word_t adr_o
);

   localparam int BEAT_W = $clog2(`DMA_DESC_BEATS);
   localparam logic [BEAT_W-1:0] BEAT_DC  = 1;  // control word beat
   localparam logic [BEAT_W-1:0] BEAT_ADR = 2;  // start address beat

   dma_pkg::dc_t          dc;
   dma_pkg::word_t        start_adr;
   logic [`DMA_LEN_W-1:0] cnt;   // strobes left after the current one

   always_ff @(posedge wb_clk_i) begin
      if (ld.load_we && ld.load_adr == BEAT_DC) begin
         dc <= dma_pkg::dc_t'(ld.load_dat[23:0]);
      end
      if (ld.load_we && ld.load_adr == BEAT_ADR) begin
         start_adr <= ld.load_dat;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         stb_o <= 1'b0;
         cnt   <= '0;
      end else if (ld.start) begin
         stb_o <= (dc.len != '0);   // zero length never strobes
         cnt   <= dc.len - 1'b1;
      end else if (stb_o) begin
         stb_o <= (cnt != '0);
         if (cnt != '0) begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // running address, first strobe carries the start address
   always_ff @(posedge wb_clk_i) begin
      if (ld.start) begin
         adr_o <= start_adr;
      end else if (stb_o) begin
         adr_o <= adr_o + 32'(`DMA_ADR_STEP);
      end
   end

   // drops with the first strobe, returns the cycle after the last
   assign ld.done = ~stb_o;

endmodule

// ==== hdl/desc_fetch.sv ====
// descriptor fetch and sequencing controller for the two-channel DMA
// reads 4-beat descriptors over a read-only Wishbone master, loads channel A
// and, when chained, channel B, starts them together and combines completion
// into the current descriptor register and the interrupt

`include "dma_cfg.svh"

module desc_fetch (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                enable_i,
   input  logic [31:3]         ndar_i,
   input  logic                ndar_dirty_i,
   input  logic                int_clear_i,
   input  dma_pkg::word_t      wbm_dat_hi_i,
   input  logic                wbm_ack_i,
   output logic                wbm_cyc_o,
   output logic                wbm_stb_o,
   output logic [3:0]          wbm_sel_o,
   output dma_pkg::word_t      wbm_adr_o,
   output logic                ndar_dirty_clear_o,
   output logic                wb_int_o,
   output logic                busy_o,
   output dma_pkg::word_t      dar_o,
   chan_load_if.fetch          ld_a,
   chan_load_if.fetch          ld_b
);

   localparam logic [1:0] LAST_BEAT = 2'(`DMA_DESC_BEATS - 1);

   dma_pkg::fetch_state_e state;
   logic [1:0]     beat;        // beat counter within a descriptor
   logic           start_a;
   logic           start_b;
   dma_pkg::word_t next_desc;   // link of the last descriptor fetched
   dma_pkg::word_t cdar;        // address of the last descriptor fetched
   dma_pkg::dc_t   dc_a;
   dma_pkg::dc_t   dc_b;
   logic           fetching;
   logic           ack_beat;
   logic           int_set;

   assign fetching = (state == dma_pkg::S_FETCH_A) || (state == dma_pkg::S_FETCH_B);
   assign ack_beat = fetching && wbm_cyc_o && wbm_ack_i;

   // strobe is held for every beat of the descriptor
   assign wbm_stb_o = wbm_cyc_o;
   assign wbm_sel_o = {4{wbm_stb_o}};

   assign ld_a.load_we  = ack_beat && (state == dma_pkg::S_FETCH_A);
   assign ld_a.load_adr = beat;
   assign ld_a.load_dat = wbm_dat_hi_i;
   assign ld_a.start    = start_a;

   assign ld_b.load_we  = ack_beat && (state == dma_pkg::S_FETCH_B);
   assign ld_b.load_adr = beat;
   assign ld_b.load_dat = wbm_dat_hi_i;
   assign ld_b.start    = start_b;

   // B only counts when A linked to it
   assign int_set = dc_a.irq | (dc_a.chain & dc_b.irq);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state              <= dma_pkg::S_IDLE;
         wbm_cyc_o          <= 1'b0;
         beat               <= 2'd0;
         start_a            <= 1'b0;
         start_b            <= 1'b0;
         ndar_dirty_clear_o <= 1'b0;
         busy_o             <= 1'b0;
         dar_o              <= '0;
      end else begin
         start_a            <= 1'b0;
         start_b            <= 1'b0;
         ndar_dirty_clear_o <= 1'b0;
         case (state)
            dma_pkg::S_IDLE: begin
               if (enable_i && ndar_dirty_i) begin
                  state              <= dma_pkg::S_FETCH_A;
                  ndar_dirty_clear_o <= 1'b1;
                  busy_o             <= 1'b1;
               end
            end
            dma_pkg::S_FETCH_A, dma_pkg::S_FETCH_B: begin
               if (!wbm_cyc_o) begin
                  wbm_cyc_o <= 1'b1;   // open the burst
               end else if (wbm_ack_i) begin
                  beat <= beat + 1'b1;  // wraps to 0 after the last beat
                  if (beat == LAST_BEAT) begin
                     wbm_cyc_o <= 1'b0;
                     if (state == dma_pkg::S_FETCH_A && dc_a.chain) begin
                        state <= dma_pkg::S_FETCH_B;
                     end else begin
                        state   <= dma_pkg::S_RUN;
                        start_a <= 1'b1;
                        start_b <= (state == dma_pkg::S_FETCH_B);
                     end
                  end
               end
            end
            dma_pkg::S_RUN: begin
               // done is stale while start is still in flight
               if (!start_a && !start_b && ld_a.done && ld_b.done) begin
                  state <= dma_pkg::S_DONE;
               end
            end
            dma_pkg::S_DONE: begin
               dar_o <= cdar;
               if (dc_a.chain && dc_b.chain) begin
                  state <= dma_pkg::S_FETCH_A;  // next pair from B's link
               end else begin
                  state  <= dma_pkg::S_IDLE;
                  busy_o <= 1'b0;
               end
            end
            default: state <= dma_pkg::S_IDLE;
         endcase
      end
   end

   // descriptor address and captured descriptor fields
   always_ff @(posedge wb_clk_i) begin
      if (state == dma_pkg::S_IDLE) begin
         wbm_adr_o <= {ndar_i, 3'b000};
      end else if (ack_beat) begin
         wbm_adr_o <= (beat == LAST_BEAT) ? next_desc : wbm_adr_o + 32'd8;
      end
      if (ack_beat && beat == 2'd0) begin
         next_desc <= {wbm_dat_hi_i[31:3], 3'b000};
         cdar      <= wbm_adr_o;
      end
      if (ack_beat && beat == 2'd1) begin
         if (state == dma_pkg::S_FETCH_A) begin
            dc_a <= dma_pkg::dc_t'(wbm_dat_hi_i[23:0]);
         end else begin
            dc_b <= dma_pkg::dc_t'(wbm_dat_hi_i[23:0]);
         end
      end
   end

   // clear has priority over a completing pair
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_int_o <= 1'b0;
      end else if (int_clear_i) begin
         wb_int_o <= 1'b0;
      end else if (state == dma_pkg::S_DONE && int_set) begin
         wb_int_o <= 1'b1;
      end
   end

endmodule

// ==== hdl/chan_load_if.sv ====
// descriptor load and run control between the fetch controller and one channel
// the fetch side writes beats and pulses start, the channel reports done

interface chan_load_if (
   input logic wb_clk_i
);

   logic           load_we;   // one cycle per acked beat
   logic [1:0]     load_adr;  // beat index within the descriptor
   dma_pkg::word_t load_dat;  // high word of the beat
   logic           start;     // one cycle pulse
   logic           done;      // level, high while the channel is quiet

   modport fetch (
      input  wb_clk_i, done,
      output load_we, load_adr, load_dat, start
   );

   modport chan (
      input  wb_clk_i, load_we, load_adr, load_dat, start,
      output done
   );

endinterface

// ==== hdl/dma_pkg.sv ====
// data types shared by the DMA fetch controller and the channel engines
// reference types by scoped name, e.g. dma_pkg::dc_t

`include "dma_cfg.svh"

package dma_pkg;

   typedef logic [31:0] word_t;

   // control word found in the high half of descriptor beat 1
   typedef struct packed {
      logic [21-`DMA_LEN_W:0] rsvd;   // unused upper bits
      logic                   irq;    // raise wb_int_o when the pair completes
      logic                   chain;  // a linked descriptor follows
      logic [`DMA_LEN_W-1:0]  len;    // words to transfer
   } dc_t;

   // fetch controller states
   typedef enum logic [2:0] {
      S_IDLE,     // waiting for enable and a dirty pointer
      S_FETCH_A,  // reading the first descriptor of a pair
      S_FETCH_B,  // reading the linked descriptor
      S_RUN,      // channels transferring
      S_DONE      // combine completions, then chain or stop
   } fetch_state_e;

endpackage

// ==== hdl/dma_cfg.svh ====
// sizing macros shared by the DMA sequencer RTL and its testbench
// include this file in any unit that needs descriptor or channel sizing

`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// a descriptor is four 64-bit beats on the bus
`define DMA_DESC_BEATS 4

// word count field of the descriptor control word
`define DMA_LEN_W 14

// byte step between consecutive channel address strobes
`define DMA_ADR_STEP 4

`endif
